/* verilog.f */
+incdir+source
source/tqv_periph_pkg.sv
source/periph_addr_decode.sv
source/periph_gpio.sv
source/periph_timer.sv
source/periph_byte_regs.sv
source/periph_read_return.sv
source/tqv_periph_top.sv
tests/tqv_periph_asserts.sv
tests/tqv_periph_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tqv_periph_tb -f verilog.f > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
status=0
./obj_dir/Vtqv_periph_tb > sim.log 2>&1 || status=1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
[ "$status" -eq 0 ] && grep -q "Simulation passed" sim.log || exit 1
exit 0

/* tests/tqv_periph_tb.sv */
// Peripheral bus testbench
`timescale 1ns/100ps
`include "tqv_periph_config.svh"

module tqv_periph_tb
    import tqv_periph_pkg::*;
();

    localparam logic [3:0] GPIO_SLOT  = 4'(`TQV_SLOT_GPIO);
    localparam logic [3:0] TIMER_SLOT = 4'(`TQV_SLOT_TIMER);
    localparam logic [3:0] BYTE_SLOT  = 4'(`TQV_SIMPLE_REGS);
    localparam logic [3:0] EMPTY_SLOT = 4'd3;
    localparam int         WAIT_LIMIT = 20;

    logic         clk;
    logic         rst_n;
    logic [7:0]   ui_in;
    periph_addr_t addr;
    logic [31:0]  wdata;
    access_size_t write_n;
    access_size_t read_n;
    logic         read_complete;
    logic [7:0]   uo_out;
    logic [31:0]  data_out;
    logic         data_ready;
    logic         interrupt;

    // Shadow of every register the host has written
    logic [7:0]   byte_shadow [4];
    logic [7:0]   gpio_shadow;
    pin_func_t    func_shadow [8];
    logic [31:0]  cmp_shadow;
    logic         timer_en;
    logic         timer_irq;
    logic         timer_pin;

    periph_addr_t addr_q [$];
    logic [31:0]  got_q [$];
    logic [31:0]  exp_q [$];
    int           value_errors;
    int           bus_errors;
    integer       seed;

    tqv_periph_top dut_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_ui_in         (ui_in),
        .i_addr          (addr),
        .i_data          (wdata),
        .i_write_n       (write_n),
        .i_read_n        (read_n),
        .i_read_complete (read_complete),
        .o_uo_out        (uo_out),
        .o_data_out      (data_out),
        .o_data_ready    (data_ready),
        .o_interrupt     (interrupt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        #200_000;
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        return $random(seed);
    endfunction

    function automatic periph_addr_t user_addr(input logic [3:0] slot, input logic [5:0] ofs);
        periph_addr_t a;
        a.user.region = 1'b0;
        a.user.slot   = slot;
        a.user.ofs    = ofs;
        return a;
    endfunction

    function automatic periph_addr_t simple_addr(input logic [3:0] slot, input logic [3:0] ofs);
        periph_addr_t a;
        a.simple.region = 1'b1;
        a.simple.unused = 2'b00;
        a.simple.slot   = slot;
        a.simple.ofs    = ofs;
        return a;
    endfunction

    function automatic logic [31:0] lane_mask(input access_size_t size);
        case (size)
            SIZE_BYTE: return 32'h0000_00ff;
            SIZE_HALF: return 32'h0000_ffff;
            SIZE_WORD: return 32'hffff_ffff;
            default:   return 32'h0;
        endcase
    endfunction

    // Expected read value from the shadow registers
    function automatic logic [31:0] ref_read(input periph_addr_t a);
        logic [31:0] v;
        v = 32'h0;
        if (a.simple.region) begin
            if (a.simple.slot == BYTE_SLOT && a.simple.ofs[3:2] == 2'b00) begin
                v = {24'h0, byte_shadow[a.simple.ofs[1:0]]};
            end
        end else if (a.user.slot == GPIO_SLOT) begin
            if (a.user.ofs == `TQV_GPIO_OUT_OFS) begin
                v = {24'h0, gpio_shadow};
            end else if (a.user.ofs == `TQV_GPIO_IN_OFS) begin
                v = {24'h0, ui_in};
            end else if (a.user.ofs[5] && a.user.ofs[1:0] == 2'b00) begin
                v = {27'h0, func_shadow[a.user.ofs[4:2]]};
            end
        end else if (a.user.slot == TIMER_SLOT) begin
            if (a.user.ofs == `TQV_TIMER_CMP_OFS) begin
                v = cmp_shadow;
            end else if (a.user.ofs == `TQV_TIMER_CTRL_OFS) begin
                v = {30'h0, timer_irq, timer_en};
            end
        end
        return v;
    endfunction

    // Output pins as routed by the pin functions
    function automatic logic [7:0] expected_pins();
        logic [7:0] pins;
        pins = 8'h0;
        for (int p = 0; p < 8; p++) begin
            if (func_shadow[p].simple) begin
                pins[p] = (func_shadow[p].slot == BYTE_SLOT) ? byte_shadow[0][p] : 1'b0;
            end else if (func_shadow[p].slot == GPIO_SLOT) begin
                pins[p] = gpio_shadow[p];
            end else if (func_shadow[p].slot == TIMER_SLOT && p == 7) begin
                pins[p] = timer_pin;
            end
        end
        return pins;
    endfunction

    task automatic check_data(input string name, input access_size_t size,
                              input logic [31:0] got, input logic [31:0] exp);
        logic [31:0] m;
        m = lane_mask(size);
        if ((got & m) !== (exp & m)) begin
            $display("[ERROR] %s: got %h, expected %h", name, got & m, exp & m);
            value_errors++;
        end
    endtask

    task automatic check_readback(input periph_addr_t a, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] o_data_out at address %h: got %h, expected %h", a, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_pins(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("[ERROR] o_uo_out: got %h, expected %h", got, exp);
            value_errors++;
        end
    endtask

    // Samples ready 1 ns after each edge, where inputs are driven too
    task automatic wait_ready(output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        while (!ok && n < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            ok = data_ready;
            n++;
        end
    endtask

    task automatic bus_write(input periph_addr_t a, input access_size_t size,
                             input logic [31:0] d);
        bit ok;
        addr    = a;
        wdata   = d;
        write_n = size;
        wait_ready(ok);
        if (!ok) begin
            $display("Write to address %h got no ready", a);
            bus_errors++;
        end
        write_n = SIZE_NONE;
    endtask

    // Holds the request for stall extra cycles before read complete
    task automatic bus_read(input periph_addr_t a, input int stall,
                            output logic [31:0] d, output bit ok);
        addr   = a;
        read_n = SIZE_WORD;
        wait_ready(ok);
        d = data_out;
        for (int c = 0; c < stall; c++) begin
            @(posedge clk);
            #1;
            if (ok) begin
                check_data("o_data_out held", SIZE_WORD, data_out, d);
            end
        end
        read_n        = SIZE_NONE;
        read_complete = ok;
        @(posedge clk);
        #1;
        read_complete = 1'b0;
    endtask

    task automatic read_check(input periph_addr_t a, input int stall);
        logic [31:0] d;
        bit          ok;
        bus_read(a, stall, d, ok);
        if (!ok) begin
            $display("Read of address %h timed out waiting for ready", a);
            bus_errors++;
        end else begin
            addr_q.push_back(a);
            got_q.push_back(d);
            exp_q.push_back(ref_read(a));
        end
    endtask

    always @(posedge clk) begin
        while (addr_q.size() > 0) begin
            check_readback(addr_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
        end
    end

    initial begin
        logic [31:0]  r;
        logic [31:0]  d;
        bit           ok;
        int           n;
        access_size_t size;
        seed          = 32'hf64c_b598;
        value_errors  = 0;
        bus_errors    = 0;
        rst_n         = 1'b0;
        ui_in         = 8'h0;
        addr          = '0;
        wdata         = 32'h0;
        write_n       = SIZE_NONE;
        read_n        = SIZE_NONE;
        read_complete = 1'b0;
        gpio_shadow   = 8'h0;
        cmp_shadow    = 32'h0;
        timer_en      = 1'b0;
        timer_irq     = 1'b0;
        timer_pin     = 1'b0;
        for (int i = 0; i < 4; i++) begin
            byte_shadow[i] = 8'h0;
        end
        for (int p = 0; p < 8; p++) begin
            func_shadow[p] = {1'b0, (p == 7) ? TIMER_SLOT : GPIO_SLOT};
        end
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state
        read_check(user_addr(GPIO_SLOT, `TQV_GPIO_OUT_OFS), 0);
        read_check(user_addr(TIMER_SLOT, `TQV_TIMER_CTRL_OFS), 0);
        for (int i = 0; i < 4; i++) begin
            read_check(simple_addr(BYTE_SLOT, 4'(i)), 0);
        end
        for (int p = 0; p < 8; p++) begin
            read_check(user_addr(GPIO_SLOT, `TQV_GPIO_FUNC_OFS + 6'(p * 4)), 0);
        end
        check_pins(uo_out, expected_pins());

        // Byte registers, including offsets past the last register
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            bus_write(simple_addr(BYTE_SLOT, r[11:8]), SIZE_BYTE, r);
            if (r[11:10] == 2'b00) begin
                byte_shadow[r[9:8]] = r[7:0];
            end
            read_check(simple_addr(BYTE_SLOT, r[11:8]), 0);
        end
        read_check(simple_addr(4'd5, 4'd0), 0);
        for (int p = 0; p < 4; p++) begin
            bus_write(user_addr(GPIO_SLOT, `TQV_GPIO_FUNC_OFS + 6'(p * 4)), SIZE_WORD,
                      {27'h0, 1'b1, BYTE_SLOT});
            func_shadow[p] = {1'b1, BYTE_SLOT};
            read_check(user_addr(GPIO_SLOT, `TQV_GPIO_FUNC_OFS + 6'(p * 4)), 0);
        end
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            bus_write(simple_addr(BYTE_SLOT, 4'd0), SIZE_BYTE, r);
            byte_shadow[0] = r[7:0];
            check_pins(uo_out, expected_pins());
        end

        // GPIO output and input readback
        for (int i = 0; i < 6; i++) begin
            r = next_random();
            ui_in = r[15:8];
            bus_write(user_addr(GPIO_SLOT, `TQV_GPIO_OUT_OFS), SIZE_WORD, r);
            gpio_shadow = r[7:0];
            check_pins(uo_out, expected_pins());
            read_check(user_addr(GPIO_SLOT, `TQV_GPIO_OUT_OFS), 0);
            read_check(user_addr(GPIO_SLOT, `TQV_GPIO_IN_OFS), 0);
        end

        // Sized writes to the compare register
        r = next_random();
        bus_write(user_addr(TIMER_SLOT, `TQV_TIMER_CMP_OFS), SIZE_WORD, r);
        cmp_shadow = r;
        for (int k = 0; k < 3; k++) begin
            size = access_size_t'(2'(k));
            d = next_random();
            bus_write(user_addr(TIMER_SLOT, `TQV_TIMER_CMP_OFS), size, d);
            cmp_shadow = (cmp_shadow & ~lane_mask(size)) | (d & lane_mask(size));
            bus_read(user_addr(TIMER_SLOT, `TQV_TIMER_CMP_OFS), 0, r, ok);
            if (!ok) begin
                $display("Read of the timer compare register timed out");
                bus_errors++;
            end
            check_data("o_data_out cmp written lanes", size, r, d);
            check_data("o_data_out cmp", SIZE_WORD, r, cmp_shadow);
        end

        // Timer interrupt, clear and pin 7 toggle
        bus_write(user_addr(TIMER_SLOT, `TQV_TIMER_CMP_OFS), SIZE_WORD, 32'd20);
        cmp_shadow = 32'd20;
        bus_write(user_addr(TIMER_SLOT, `TQV_TIMER_CTRL_OFS), SIZE_WORD, 32'h1);
        timer_en = 1'b1;
        n = 0;
        while (!interrupt && n < 200) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!interrupt) begin
            $display("Timer interrupt did not rise within 200 cycles");
            bus_errors++;
        end else begin
            timer_irq = 1'b1;
            timer_pin = ~timer_pin;
        end
        read_check(user_addr(TIMER_SLOT, `TQV_TIMER_CTRL_OFS), 0);
        check_pins(uo_out, expected_pins());
        bus_write(user_addr(TIMER_SLOT, `TQV_TIMER_CTRL_OFS), SIZE_WORD, 32'h2);
        timer_en  = 1'b0;
        timer_irq = 1'b0;
        check_data("o_interrupt", SIZE_BYTE, {31'h0, interrupt}, 32'h0);
        read_check(user_addr(TIMER_SLOT, `TQV_TIMER_CTRL_OFS), 0);
        check_pins(uo_out, expected_pins());

        // Back-pressure with random read complete delay
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            read_check(user_addr(GPIO_SLOT, `TQV_GPIO_OUT_OFS), 1 + int'(r[2:0]));
            read_check(simple_addr(BYTE_SLOT, 4'(i)), 1 + int'(r[5:3]));
            read_check(user_addr(TIMER_SLOT, `TQV_TIMER_CMP_OFS), 1 + int'(r[8:6]));
        end

        // Empty user slot never answers
        bus_read(user_addr(EMPTY_SLOT, 6'h00), 0, d, ok);
        if (ok) begin
            $display("Read of empty user slot 3 returned ready");
            bus_errors++;
        end else begin
            $display("Read of empty user slot 3 timed out as expected");
        end

        n = 0;
        while (addr_q.size() > 0 && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (addr_q.size() != 0) begin
            $display("Compare queue still held %0d reads at the end", addr_q.size());
            bus_errors++;
        end
        $display("Checks done: %0d value errors, %0d bus errors", value_errors, bus_errors);
        if (value_errors == 0 && bus_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tests/tqv_periph_asserts.sv */
// Bus protocol assertions
`timescale 1ns/100ps
`include "tqv_periph_config.svh"

module tqv_periph_asserts
    import tqv_periph_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input periph_addr_t i_addr,
    input logic [31:0]  i_data,
    input access_size_t i_write_n,
    input access_size_t i_read_n,
    input logic         i_read_complete,
    input logic [31:0]  o_data_out,
    input logic         o_data_ready,
    input logic         o_interrupt
);

    logic read_req;
    logic write_req;
    logic ctrl_clear;

    assign read_req   = (i_read_n != SIZE_NONE);
    assign write_req  = (i_write_n != SIZE_NONE);
    assign ctrl_clear = write_req && !i_addr.user.region
                        && i_addr.user.slot == 4'(`TQV_SLOT_TIMER)
                        && i_addr.user.ofs == `TQV_TIMER_CTRL_OFS && i_data[1];

    // Held read data stays put until the host completes the read
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        o_data_ready && read_req && !i_read_complete |=> $stable(o_data_out))
        else $error("o_data_out changed while the read was held");

    // Ready outlives the request only into the read complete cycle
    ready_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        o_data_ready |-> read_req || write_req || i_read_complete)
        else $error("o_data_ready high without a request");

    irq_clear: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_clear |=> !o_interrupt)
        else $error("o_interrupt still high after a clear write");

endmodule

bind tqv_periph_top tqv_periph_asserts asserts_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_addr          (i_addr),
    .i_data          (i_data),
    .i_write_n       (i_write_n),
    .i_read_n        (i_read_n),
    .i_read_complete (i_read_complete),
    .o_data_out      (o_data_out),
    .o_data_ready    (o_data_ready),
    .o_interrupt     (o_interrupt)
);

/* source/tqv_periph_top.sv */
// Peripheral bus top level
`timescale 1ns/100ps
`include "tqv_periph_config.svh"

module tqv_periph_top
    import tqv_periph_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic [7:0]   i_ui_in,
    input  periph_addr_t i_addr,
    input  logic [31:0]  i_data,
    input  access_size_t i_write_n,
    input  access_size_t i_read_n,
    input  logic         i_read_complete,
    output logic [7:0]   o_uo_out,
    output logic [31:0]  o_data_out,
    output logic         o_data_ready,
    output logic         o_interrupt
);

    logic [`TQV_SLOTS-1:0] user_sel;
    logic [`TQV_SLOTS-1:0] simple_sel;
    logic [5:0]            user_ofs;
    logic [3:0]            simple_ofs;
    access_size_t          gpio_write_n;
    access_size_t          timer_write_n;
    access_size_t          timer_read_n;
    logic                  simple_write;

    logic [31:0] user_rdata   [`TQV_SLOTS];
    logic        user_ready   [`TQV_SLOTS];
    logic [7:0]  user_pins    [`TQV_SLOTS];
    logic [7:0]  simple_rdata [`TQV_SLOTS];
    logic [7:0]  simple_pins  [`TQV_SLOTS];

    periph_addr_decode decode_i (
        .i_addr          (i_addr),
        .i_write_n       (i_write_n),
        .i_read_n        (i_read_n),
        .o_user_sel      (user_sel),
        .o_simple_sel    (simple_sel),
        .o_user_ofs      (user_ofs),
        .o_simple_ofs    (simple_ofs),
        .o_gpio_write_n  (gpio_write_n),
        .o_gpio_read_n   (),
        .o_timer_write_n (timer_write_n),
        .o_timer_read_n  (timer_read_n),
        .o_simple_write  (simple_write)
    );

    // GPIO supplies its own output byte inside the pin mux
    periph_gpio gpio_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_ofs         (user_ofs),
        .i_write_n     (gpio_write_n),
        .i_data        (i_data),
        .i_ui_in       (i_ui_in),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_rdata       (user_rdata[`TQV_SLOT_GPIO]),
        .o_ready       (user_ready[`TQV_SLOT_GPIO]),
        .o_uo_out      (o_uo_out)
    );

    periph_timer timer_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_ofs       (user_ofs),
        .i_write_n   (timer_write_n),
        .i_read_n    (timer_read_n),
        .i_data      (i_data),
        .o_rdata     (user_rdata[`TQV_SLOT_TIMER]),
        .o_ready     (user_ready[`TQV_SLOT_TIMER]),
        .o_uo_out    (user_pins[`TQV_SLOT_TIMER]),
        .o_interrupt (o_interrupt)
    );

    periph_byte_regs byte_regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_ofs    (simple_ofs),
        .i_write  (simple_write),
        .i_data   (i_data[7:0]),
        .o_rdata  (simple_rdata[`TQV_SIMPLE_REGS]),
        .o_uo_out (simple_pins[`TQV_SIMPLE_REGS])
    );

    // Unallocated slots read zero, user slots never become ready
    for (genvar s = 0; s < `TQV_SLOTS; s++) begin : g_tie
        if (s != `TQV_SLOT_GPIO && s != `TQV_SLOT_TIMER) begin : g_user
            assign user_rdata[s] = '0;
            assign user_ready[s] = 1'b0;
        end
        if (s != `TQV_SLOT_TIMER) begin : g_user_pins
            assign user_pins[s] = '0;
        end
        if (s != `TQV_SIMPLE_REGS) begin : g_simple
            assign simple_rdata[s] = '0;
            assign simple_pins[s]  = '0;
        end
    end

    periph_read_return read_return_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_read_n),
        .i_write_n       (i_write_n),
        .i_read_complete (i_read_complete),
        .i_user_sel      (user_sel),
        .i_simple_sel    (simple_sel),
        .i_user_rdata    (user_rdata),
        .i_user_ready    (user_ready),
        .i_simple_rdata  (simple_rdata),
        .o_data_out      (o_data_out),
        .o_data_ready    (o_data_ready)
    );

endmodule

/* source/periph_read_return.sv */
// Read data return and hold
`timescale 1ns/100ps
`include "tqv_periph_config.svh"

module periph_read_return
    import tqv_periph_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  access_size_t          i_read_n,
    input  access_size_t          i_write_n,
    input  logic                  i_read_complete,
    input  logic [`TQV_SLOTS-1:0] i_user_sel,
    input  logic [`TQV_SLOTS-1:0] i_simple_sel,
    input  logic [31:0]           i_user_rdata   [`TQV_SLOTS],
    input  logic                  i_user_ready   [`TQV_SLOTS],
    input  logic [7:0]            i_simple_rdata [`TQV_SLOTS],
    output logic [31:0]           o_data_out,
    output logic                  o_data_ready
);

    logic [31:0] periph_data;
    logic        periph_ready;
    logic [31:0] data_q;
    logic        hold;
    logic        last_req;
    logic        ready_q;
    logic        read_req;
    logic        capture;

    // Selects are one-hot, byte slots are always ready
    always_comb begin
        periph_data  = '0;
        periph_ready = 1'b0;
        for (int s = 0; s < `TQV_SLOTS; s++) begin
            if (i_user_sel[s]) begin
                periph_data  = i_user_rdata[s];
                periph_ready = i_user_ready[s];
            end
            if (i_simple_sel[s]) begin
                periph_data  = {24'h0, i_simple_rdata[s]};
                periph_ready = 1'b1;
            end
        end
    end

    assign read_req = (i_read_n != SIZE_NONE);
    // Data is taken on the same edge that raises ready
    assign capture  = !hold && last_req && periph_ready && read_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold     <= 1'b0;
            last_req <= 1'b0;
            ready_q  <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            last_req <= read_req;
            ready_q  <= last_req && read_req && periph_ready;
        end
    end

    // Held value stays put until read complete
    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= periph_data;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_write_n != SIZE_NONE);

endmodule

/* source/periph_byte_regs.sv */
// Byte register block
`timescale 1ns/100ps

module periph_byte_regs (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [3:0] i_ofs,
    input  logic       i_write,
    input  logic [7:0] i_data,
    output logic [7:0] o_rdata,
    output logic [7:0] o_uo_out
);

    logic [7:0] regs [4];
    logic       hit;

    // Only offsets 0 to 3 hold a register
    assign hit = (i_ofs[3:2] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 4; r++) begin
                regs[r] <= '0;
            end
        end else if (i_write && hit) begin
            regs[i_ofs[1:0]] <= i_data;
        end
    end

    assign o_rdata  = hit ? regs[i_ofs[1:0]] : 8'h0;
    assign o_uo_out = regs[0];

endmodule

/* source/periph_timer.sv */
// Compare timer
`timescale 1ns/100ps
`include "tqv_periph_config.svh"

module periph_timer
    import tqv_periph_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic [5:0]   i_ofs,
    input  access_size_t i_write_n,
    input  access_size_t i_read_n,
    input  logic [31:0]  i_data,
    output logic [31:0]  o_rdata,
    output logic         o_ready,
    output logic [7:0]   o_uo_out,
    output logic         o_interrupt
);

    logic [31:0] count;
    logic [31:0] cmp;
    logic        enable;
    logic        irq;
    logic        pin_toggle;
    logic        read_seen;
    logic        ready_q;
    logic        write_req;
    logic        read_req;
    logic [31:0] wmask;

    function automatic logic [31:0] size_mask(access_size_t size);
        case (size)
            SIZE_BYTE: size_mask = 32'h0000_00ff;
            SIZE_HALF: size_mask = 32'h0000_ffff;
            default:   size_mask = 32'hffff_ffff;
        endcase
    endfunction

    assign write_req = (i_write_n != SIZE_NONE);
    assign read_req  = (i_read_n != SIZE_NONE);
    assign wmask     = size_mask(i_write_n);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count      <= '0;
            cmp        <= '0;
            enable     <= 1'b0;
            irq        <= 1'b0;
            pin_toggle <= 1'b0;
        end else begin
            if (write_req && i_ofs == `TQV_TIMER_COUNT_OFS) begin
                count <= (count & ~wmask) | (i_data & wmask);
            end else if (enable) begin
                count <= count + 32'd1;
            end
            if (write_req && i_ofs == `TQV_TIMER_CMP_OFS) begin
                cmp <= (cmp & ~wmask) | (i_data & wmask);
            end
            if (enable && count == cmp) begin
                irq        <= 1'b1;
                pin_toggle <= ~pin_toggle;
            end
            // Clear wins over a match in the same cycle
            if (write_req && i_ofs == `TQV_TIMER_CTRL_OFS) begin
                enable <= i_data[0];
                if (i_data[1]) begin
                    irq <= 1'b0;
                end
            end
        end
    end

    // Ready comes two edges into the request, one later than the others
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            read_seen <= 1'b0;
            ready_q   <= 1'b0;
        end else begin
            read_seen <= read_req;
            ready_q   <= read_seen && read_req;
        end
    end

    always_comb begin
        case (i_ofs)
            `TQV_TIMER_COUNT_OFS: o_rdata = count;
            `TQV_TIMER_CMP_OFS:   o_rdata = cmp;
            `TQV_TIMER_CTRL_OFS:  o_rdata = {30'h0, irq, enable};
            default:              o_rdata = '0;
        endcase
    end

    assign o_ready     = ready_q;
    assign o_uo_out    = {pin_toggle, 7'h0};
    assign o_interrupt = irq;

endmodule

/* source/periph_gpio.sv */
// GPIO and output pin routing
`timescale 1ns/100ps
`include "tqv_periph_config.svh"

module periph_gpio
    import tqv_periph_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic [5:0]   i_ofs,
    input  access_size_t i_write_n,
    input  logic [31:0]  i_data,
    input  logic [7:0]   i_ui_in,
    input  logic [7:0]   i_user_pins   [`TQV_SLOTS],
    input  logic [7:0]   i_simple_pins [`TQV_SLOTS],
    output logic [31:0]  o_rdata,
    output logic         o_ready,
    output logic [7:0]   o_uo_out
);

    localparam logic [39:0] FUNC_RESET = `TQV_PIN_FUNC_RESET;

    logic [7:0] gpio_out;
    pin_func_t  func_sel [8];
    logic       write_req;
    logic       func_hit;
    logic [2:0] func_idx;

    assign write_req = (i_write_n != SIZE_NONE);
    // Pin index lives in offset bits 4:2
    assign func_hit  = ((i_ofs & ~6'h1c) == `TQV_GPIO_FUNC_OFS);
    assign func_idx  = i_ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int p = 0; p < 8; p++) begin
                func_sel[p] <= FUNC_RESET[p*5 +: 5];
            end
        end else if (write_req) begin
            if (i_ofs == `TQV_GPIO_OUT_OFS) begin
                gpio_out <= i_data[7:0];
            end
            if (func_hit) begin
                func_sel[func_idx] <= i_data[4:0];
            end
        end
    end

    always_comb begin
        if (i_ofs == `TQV_GPIO_OUT_OFS) begin
            o_rdata = {24'h0, gpio_out};
        end else if (i_ofs == `TQV_GPIO_IN_OFS) begin
            o_rdata = {24'h0, i_ui_in};
        end else if (func_hit) begin
            o_rdata = {27'h0, func_sel[func_idx]};
        end else begin
            o_rdata = '0;
        end
    end

    assign o_ready = 1'b1;

    // Each pin takes its own bit from the byte of the named slot
    always_comb begin
        for (int p = 0; p < 8; p++) begin
            if (func_sel[p].simple) begin
                o_uo_out[p] = i_simple_pins[func_sel[p].slot][p];
            end else if (func_sel[p].slot == 4'(`TQV_SLOT_GPIO)) begin
                o_uo_out[p] = gpio_out[p];
            end else begin
                o_uo_out[p] = i_user_pins[func_sel[p].slot][p];
            end
        end
    end

endmodule

/* source/periph_addr_decode.sv */
// Peripheral address decode
`timescale 1ns/100ps
`include "tqv_periph_config.svh"

module periph_addr_decode
    import tqv_periph_pkg::*;
(
    input  periph_addr_t          i_addr,
    input  access_size_t          i_write_n,
    input  access_size_t          i_read_n,
    output logic [`TQV_SLOTS-1:0] o_user_sel,
    output logic [`TQV_SLOTS-1:0] o_simple_sel,
    output logic [5:0]            o_user_ofs,
    output logic [3:0]            o_simple_ofs,
    output access_size_t          o_gpio_write_n,
    output access_size_t          o_gpio_read_n,
    output access_size_t          o_timer_write_n,
    output access_size_t          o_timer_read_n,
    output logic                  o_simple_write
);

    // Region bit sits in the same place in both views
    always_comb begin
        o_user_sel   = '0;
        o_simple_sel = '0;
        if (i_addr.user.region) begin
            o_simple_sel[i_addr.simple.slot] = 1'b1;
        end else begin
            o_user_sel[i_addr.user.slot] = 1'b1;
        end
    end

    assign o_user_ofs   = i_addr.user.ofs;
    assign o_simple_ofs = i_addr.simple.ofs;

    // Deselected peripherals see no request
    assign o_gpio_write_n  = o_user_sel[`TQV_SLOT_GPIO]  ? i_write_n : SIZE_NONE;
    assign o_gpio_read_n   = o_user_sel[`TQV_SLOT_GPIO]  ? i_read_n  : SIZE_NONE;
    assign o_timer_write_n = o_user_sel[`TQV_SLOT_TIMER] ? i_write_n : SIZE_NONE;
    assign o_timer_read_n  = o_user_sel[`TQV_SLOT_TIMER] ? i_read_n  : SIZE_NONE;

    assign o_simple_write = (i_write_n != SIZE_NONE) && o_simple_sel[`TQV_SIMPLE_REGS];

endmodule

/* source/tqv_periph_pkg.sv */
// Peripheral bus types
package tqv_periph_pkg;

    // Host read and write size code
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_t;

    // 64 byte slots of the full interface peripherals
    typedef struct packed {
        logic       region;
        logic [3:0] slot;
        logic [5:0] ofs;
    } user_view_t;

    // 16 byte slots of the byte peripherals
    typedef struct packed {
        logic       region;
        logic [1:0] unused;
        logic [3:0] slot;
        logic [3:0] ofs;
    } simple_view_t;

    typedef union packed {
        user_view_t   user;
        simple_view_t simple;
    } periph_addr_t;

    // Output pin source, simple set selects the byte peripherals
    typedef struct packed {
        logic       simple;
        logic [3:0] slot;
    } pin_func_t;

endpackage

/* source/tqv_periph_config.svh */
// Peripheral bus configuration
`ifndef TQV_PERIPH_CONFIG_SVH
`define TQV_PERIPH_CONFIG_SVH

// Bus and slot geometry
`define TQV_ADDR_W          11
`define TQV_SLOTS           16

// Slot allocation
`define TQV_SLOT_GPIO       1
`define TQV_SLOT_TIMER      2
`define TQV_SIMPLE_REGS     0

// GPIO register offsets, function select registers are 4 bytes apart
`define TQV_GPIO_OUT_OFS    6'h00
`define TQV_GPIO_IN_OFS     6'h04
`define TQV_GPIO_FUNC_OFS   6'h20

// Timer register offsets
`define TQV_TIMER_COUNT_OFS 6'h00
`define TQV_TIMER_CMP_OFS   6'h04
`define TQV_TIMER_CTRL_OFS  6'h08

// Pin 7 on the timer, pins 6 to 0 on GPIO
`define TQV_PIN_FUNC_RESET  {5'h02, {7{5'h01}}}

`endif
